/* logic/flit_if.sv */
// Flit stream between endpoint blocks
// Valid/ready handshake, last marks the final flit of a packet
`timescale 1ns/1ps
`default_nettype none

interface flit_if;
   logic [noc_pkg::flit_width-1:0] flit;
   logic last;
   logic valid;
   logic ready;

   // Sending side
   modport tx (output flit, output last, output valid, input ready);

   // Receiving side
   modport rx (input flit, input last, input valid, output ready);
endinterface

`default_nettype wire

/* logic/mp_bus_regs.sv */
// Bus slave of the endpoint
// Decodes the word index, holds the enable bit, builds the status word
// and routes data window accesses to the egress and ingress paths
`timescale 1ns/1ps
`default_nettype none

module mp_bus_regs (
   input  logic clk,
   input  logic rst,
   input  logic [31:0] bus_addr,
   input  logic bus_we,
   input  logic bus_en,
   input  logic [noc_pkg::flit_width-1:0] bus_data_in,
   output logic [noc_pkg::flit_width-1:0] bus_data_out,
   output logic bus_ack,
   output logic bus_err,
   output logic wr_req,
   output logic [noc_pkg::flit_width-1:0] wr_data,
   output logic rd_req,
   input  logic wr_ack,
   input  logic rd_ack,
   input  logic [noc_pkg::flit_width-1:0] rd_data,
   input  logic rx_avail,
   input  logic tx_busy,
   output logic enabled
);
   logic [3:0] word_idx;
   logic set_en;

   assign word_idx = bus_addr[5:2];
   // Written data goes straight to the egress sequencer
   assign wr_data = bus_data_in;

   // Same-cycle answer to every access
   always_comb begin
      bus_ack = 1'b0;
      bus_err = 1'b0;
      bus_data_out = '0;
      wr_req = 1'b0;
      rd_req = 1'b0;
      set_en = 1'b0;
      if (bus_en) begin
         case (word_idx)
            mp_pkg::addr_data: begin
               if (bus_we) begin
                  wr_req = 1'b1;
                  bus_ack = wr_ack;
               end else begin
                  rd_req = 1'b1;
                  bus_ack = rd_ack;
                  bus_data_out = rd_data;
               end
            end
            mp_pkg::addr_ctrl: begin
               bus_ack = 1'b1;
               if (bus_we) begin
                  set_en = 1'b1;
               end else begin
                  bus_data_out[mp_pkg::status_rx_bit] = rx_avail;
                  bus_data_out[mp_pkg::status_tx_bit] = tx_busy;
                  bus_data_out[mp_pkg::status_en_bit] = enabled;
               end
            end
            default: begin
               bus_err = 1'b1;
            end
         endcase
      end
   end

   // Any control write turns the endpoint on
   always_ff @(posedge clk) begin
      if (rst) begin
         enabled <= 1'b0;
      end else if (set_en) begin
         enabled <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/mp_ctrl_responder.sv */
// Control message handling between the buffers and the NoC ports
// Requests at the input are swallowed and answered, replies go out between egress packets
`timescale 1ns/1ps
`default_nettype none

module mp_ctrl_responder (
   input  logic clk,
   input  logic rst,
   input  logic [noc_pkg::flit_width-1:0] noc_in_flit,
   input  logic noc_in_last,
   input  logic noc_in_valid,
   output logic noc_in_ready,
   output logic [noc_pkg::flit_width-1:0] noc_out_flit,
   output logic noc_out_last,
   output logic noc_out_valid,
   input  logic noc_out_ready,
   input  logic enabled,
   flit_if.rx eg_s,
   flit_if.tx ing_s
);
   // Input is past the header of a multi-flit packet
   logic in_mid;
   logic is_req;
   logic pending;
   logic [noc_pkg::flit_width-1:0] reply_flit;
   logic [noc_pkg::flit_width-1:0] reply_next;
   // Egress packet has started on the output
   logic eg_mid;
   // Egress flit shown last cycle and not yet taken
   logic eg_hold;
   logic sel_reply;

   // Only a single flit packet can be a request
   assign is_req = noc_in_valid && noc_in_last && !in_mid
                   && (noc_in_flit[noc_pkg::class_msb:noc_pkg::class_lsb] == noc_pkg::ctrl_class)
                   && !noc_in_flit[noc_pkg::ctrl_reply_bit];

   // Input stalls while a reply waits
   assign noc_in_ready = !pending && (is_req || ing_s.ready);
   assign ing_s.flit = noc_in_flit;
   assign ing_s.last = noc_in_last;
   assign ing_s.valid = noc_in_valid && !pending && !is_req;

   // Swap source and destination, keep class and the rest
   always_comb begin
      reply_next = noc_in_flit;
      reply_next[noc_pkg::dest_msb:noc_pkg::dest_lsb] =
         noc_in_flit[noc_pkg::src_msb:noc_pkg::src_lsb];
      reply_next[noc_pkg::src_msb:noc_pkg::src_lsb] =
         noc_in_flit[noc_pkg::dest_msb:noc_pkg::dest_lsb];
      reply_next[noc_pkg::ctrl_enable_bit] = enabled;
      reply_next[noc_pkg::ctrl_reply_bit] = 1'b1;
   end

   // Reply never cuts into a packet or replaces a flit already on offer
   assign sel_reply = pending && !eg_mid && !eg_hold;
   assign noc_out_valid = sel_reply || eg_s.valid;
   assign noc_out_flit = sel_reply ? reply_flit : eg_s.flit;
   assign noc_out_last = sel_reply || eg_s.last;
   assign eg_s.ready = !sel_reply && noc_out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         in_mid <= 1'b0;
         pending <= 1'b0;
         eg_mid <= 1'b0;
         eg_hold <= 1'b0;
      end else begin
         if (noc_in_valid && noc_in_ready) begin
            in_mid <= !noc_in_last;
         end
         // Accept and send cannot coincide
         if (is_req && noc_in_ready) begin
            pending <= 1'b1;
         end else if (sel_reply && noc_out_ready) begin
            pending <= 1'b0;
         end
         if (eg_s.valid && eg_s.ready) begin
            eg_mid <= !eg_s.last;
         end
         eg_hold <= !sel_reply && eg_s.valid && !noc_out_ready;
      end
   end

   always_ff @(posedge clk) begin
      if (is_req && noc_in_ready) begin
         reply_flit <= reply_next;
      end
   end

endmodule

`default_nettype wire

/* logic/mp_egress_seq.sv */
// Egress sequencer
// First data window write is the packet size, the following writes are its flits
`timescale 1ns/1ps
`default_nettype none

module mp_egress_seq (
   input  logic clk,
   input  logic rst,
   input  logic wr_req,
   input  logic [noc_pkg::flit_width-1:0] wr_data,
   output logic wr_ack,
   flit_if.tx out_s
);
   mp_pkg::egress_state_e state;
   // Flits still to come in this packet
   logic [mp_pkg::size_width-1:0] remaining;

   assign out_s.flit = wr_data;
   assign out_s.last = (remaining == mp_pkg::size_width'(1));
   // Master holds the write until ack, so valid stays up until ready
   assign out_s.valid = wr_req && (state == mp_pkg::eg_flits);
   // Size is taken at once, flits wait for buffer space
   assign wr_ack = (state == mp_pkg::eg_idle) ? wr_req : (wr_req && out_s.ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mp_pkg::eg_idle;
         remaining <= '0;
      end else begin
         case (state)
            mp_pkg::eg_idle: begin
               if (wr_req) begin
                  remaining <= wr_data[mp_pkg::size_width-1:0];
                  // Zero size is dropped
                  if (wr_data[mp_pkg::size_width-1:0] != '0) begin
                     state <= mp_pkg::eg_flits;
                  end
               end
            end
            mp_pkg::eg_flits: begin
               if (out_s.valid && out_s.ready) begin
                  remaining <= remaining - 1'b1;
                  if (out_s.last) begin
                     state <= mp_pkg::eg_idle;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/mp_endpoint.sv */
// Message passing endpoint top level
// Bus side register window, NoC side flit ports, irq while a received packet waits
`timescale 1ns/1ps
`default_nettype none

module mp_endpoint (
   input  logic clk,
   input  logic rst,
   input  logic [31:0] bus_addr,
   input  logic bus_we,
   input  logic bus_en,
   input  logic [noc_pkg::flit_width-1:0] bus_data_in,
   output logic [noc_pkg::flit_width-1:0] bus_data_out,
   output logic bus_ack,
   output logic bus_err,
   input  logic [noc_pkg::flit_width-1:0] noc_in_flit,
   input  logic noc_in_last,
   input  logic noc_in_valid,
   output logic noc_in_ready,
   output logic [noc_pkg::flit_width-1:0] noc_out_flit,
   output logic noc_out_last,
   output logic noc_out_valid,
   input  logic noc_out_ready,
   output logic irq
);
   logic wr_req;
   logic [noc_pkg::flit_width-1:0] wr_data;
   logic wr_ack;
   logic rd_req;
   logic [noc_pkg::flit_width-1:0] rd_data;
   logic rd_ack;
   logic enabled;
   logic [mp_pkg::size_width-1:0] ing_size;

   // Sequencer to egress buffer, egress buffer to responder
   flit_if eg_seq_s ();
   flit_if eg_buf_s ();
   // Responder to ingress buffer, ingress buffer to reader
   flit_if ing_rsp_s ();
   flit_if ing_buf_s ();

   assign irq = ing_buf_s.valid;

   mp_bus_regs u_bus_regs (
      .clk          (clk),
      .rst          (rst),
      .bus_addr     (bus_addr),
      .bus_we       (bus_we),
      .bus_en       (bus_en),
      .bus_data_in  (bus_data_in),
      .bus_data_out (bus_data_out),
      .bus_ack      (bus_ack),
      .bus_err      (bus_err),
      .wr_req       (wr_req),
      .wr_data      (wr_data),
      .rd_req       (rd_req),
      .wr_ack       (wr_ack),
      .rd_ack       (rd_ack),
      .rd_data      (rd_data),
      .rx_avail     (ing_buf_s.valid),
      .tx_busy      (eg_buf_s.valid),
      .enabled      (enabled)
   );

   mp_egress_seq u_egress_seq (
      .clk     (clk),
      .rst     (rst),
      .wr_req  (wr_req),
      .wr_data (wr_data),
      .wr_ack  (wr_ack),
      .out_s   (eg_seq_s)
   );

   mp_packet_buffer #(
      .depth (mp_pkg::buf_depth)
   ) u_egress_buf (
      .clk      (clk),
      .rst      (rst),
      .in_s     (eg_seq_s),
      .out_s    (eg_buf_s),
      .out_size ()
   );

   mp_ctrl_responder u_ctrl_responder (
      .clk           (clk),
      .rst           (rst),
      .noc_in_flit   (noc_in_flit),
      .noc_in_last   (noc_in_last),
      .noc_in_valid  (noc_in_valid),
      .noc_in_ready  (noc_in_ready),
      .noc_out_flit  (noc_out_flit),
      .noc_out_last  (noc_out_last),
      .noc_out_valid (noc_out_valid),
      .noc_out_ready (noc_out_ready),
      .enabled       (enabled),
      .eg_s          (eg_buf_s),
      .ing_s         (ing_rsp_s)
   );

   mp_packet_buffer #(
      .depth (mp_pkg::buf_depth)
   ) u_ingress_buf (
      .clk      (clk),
      .rst      (rst),
      .in_s     (ing_rsp_s),
      .out_s    (ing_buf_s),
      .out_size (ing_size)
   );

   mp_ingress_reader u_ingress_reader (
      .clk     (clk),
      .rst     (rst),
      .rd_req  (rd_req),
      .rd_data (rd_data),
      .rd_ack  (rd_ack),
      .size    (ing_size),
      .in_s    (ing_buf_s)
   );

endmodule

`default_nettype wire

/* logic/mp_ingress_reader.sv */
// Ingress reader
// A data window read returns the head packet size, or 0 with nothing waiting,
// then one flit per read until the packet is drained
`timescale 1ns/1ps
`default_nettype none

module mp_ingress_reader (
   input  logic clk,
   input  logic rst,
   input  logic rd_req,
   output logic [noc_pkg::flit_width-1:0] rd_data,
   output logic rd_ack,
   input  logic [mp_pkg::size_width-1:0] size,
   flit_if.rx in_s
);
   mp_pkg::ingress_state_e state;

   always_comb begin
      rd_ack = 1'b0;
      rd_data = '0;
      in_s.ready = 1'b0;
      case (state)
         mp_pkg::ing_idle: begin
            rd_ack = rd_req;
            if (in_s.valid) begin
               rd_data = {{(noc_pkg::flit_width - mp_pkg::size_width){1'b0}}, size};
            end
         end
         mp_pkg::ing_flits: begin
            // Each read pops one flit
            in_s.ready = rd_req;
            rd_ack = rd_req && in_s.valid;
            rd_data = in_s.flit;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mp_pkg::ing_idle;
      end else begin
         case (state)
            mp_pkg::ing_idle: begin
               if (rd_req && in_s.valid) begin
                  state <= mp_pkg::ing_flits;
               end
            end
            mp_pkg::ing_flits: begin
               if (in_s.valid && in_s.ready && in_s.last) begin
                  state <= mp_pkg::ing_idle;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/mp_packet_buffer.sv */
// Packet FIFO for flit streams
// Presents only complete packets on the output and reports the head packet length
`timescale 1ns/1ps
`default_nettype none

module mp_packet_buffer #(
   parameter int depth = mp_pkg::buf_depth
) (
   input  logic clk,
   input  logic rst,
   flit_if.rx in_s,
   flit_if.tx out_s,
   output logic [mp_pkg::size_width-1:0] out_size
);
   localparam int ptr_width = $clog2(depth);
   localparam int cnt_width = $clog2(depth + 1);

   // Flit store, last marker kept above the data bits
   logic [noc_pkg::flit_width:0] flit_mem [depth];
   // Lengths of stored complete packets, in arrival order
   logic [mp_pkg::size_width-1:0] len_mem [depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   logic [ptr_width-1:0] len_wr_ptr;
   logic [ptr_width-1:0] len_rd_ptr;
   logic [cnt_width-1:0] flit_cnt;
   logic [cnt_width-1:0] pkt_cnt;
   // Flits taken so far of the packet being received
   logic [mp_pkg::size_width-1:0] cur_len;
   logic push;
   logic pop;
   logic push_last;
   logic pop_last;

   // Wraps for depths that are not a power of two
   function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
      if (ptr == ptr_width'(depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign in_s.ready = (flit_cnt != cnt_width'(depth));
   assign push = in_s.valid && in_s.ready;
   assign push_last = push && in_s.last;
   assign pop = out_s.valid && out_s.ready;
   assign pop_last = pop && out_s.last;

   // Head is always part of a complete packet while pkt_cnt is nonzero
   assign out_s.valid = (pkt_cnt != '0);
   assign out_s.flit = flit_mem[rd_ptr][noc_pkg::flit_width-1:0];
   assign out_s.last = flit_mem[rd_ptr][noc_pkg::flit_width];
   assign out_size = len_mem[len_rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         len_wr_ptr <= '0;
         len_rd_ptr <= '0;
         flit_cnt <= '0;
         pkt_cnt <= '0;
         cur_len <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
            cur_len <= push_last ? '0 : cur_len + 1'b1;
         end
         if (push_last) begin
            len_wr_ptr <= ptr_inc(len_wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (pop_last) begin
            len_rd_ptr <= ptr_inc(len_rd_ptr);
         end
         flit_cnt <= flit_cnt + cnt_width'(push) - cnt_width'(pop);
         // Packet becomes visible the cycle after its last flit
         pkt_cnt <= pkt_cnt + cnt_width'(push_last) - cnt_width'(pop_last);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         flit_mem[wr_ptr] <= {in_s.last, in_s.flit};
      end
      if (push_last) begin
         len_mem[len_wr_ptr] <= cur_len + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/mp_pkg.sv */
// Message passing endpoint definitions
// Register map, buffer sizing and FSM state types
`default_nettype none

package mp_pkg;

   // Default packet buffer depth in flits
   localparam int buf_depth = 16;

   // Size word width, holds up to buf_depth
   localparam int size_width = 5;

   // Word indices decoded from bus_addr[5:2]
   localparam logic [3:0] addr_data = 4'd0;
   localparam logic [3:0] addr_ctrl = 4'd1;

   // Status word bits
   localparam int status_rx_bit = 0;
   localparam int status_tx_bit = 1;
   localparam int status_en_bit = 2;

   // Egress FSM, waits for size then takes flits
   typedef enum logic {eg_idle, eg_flits} egress_state_e;

   // Ingress FSM, returns size then pops flits
   typedef enum logic {ing_idle, ing_flits} ingress_state_e;

endpackage

`default_nettype wire

/* logic/noc_pkg.sv */
// NoC flit format shared by the endpoint and its testbench
// Header field positions and the control message encoding
`default_nettype none

package noc_pkg;

   // Flit width, also the bus data width
   localparam int flit_width = 32;

   // Destination tile
   localparam int dest_lsb = 27;
   localparam int dest_msb = 31;

   // Message class
   localparam int class_lsb = 24;
   localparam int class_msb = 26;

   // Source tile
   localparam int src_lsb = 19;
   localparam int src_msb = 23;

   // Control messages are answered by the endpoint itself
   localparam logic [2:0] ctrl_class = 3'd7;
   localparam int ctrl_reply_bit = 0;
   localparam int ctrl_enable_bit = 1;

endpackage

`default_nettype wire

/* mp_endpoint.f */
logic/noc_pkg.sv
logic/mp_pkg.sv
logic/flit_if.sv
logic/mp_packet_buffer.sv
logic/mp_bus_regs.sv
logic/mp_egress_seq.sv
logic/mp_ingress_reader.sv
logic/mp_ctrl_responder.sv
logic/mp_endpoint.sv
sim/mp_endpoint_assert.sv
sim/mp_endpoint_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the endpoint testbench with Verilator, runs it and searches the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module mp_endpoint_tb -f mp_endpoint.f -o mp_endpoint_sim || exit 1
./obj_dir/mp_endpoint_sim > sim.log 2>&1
run_status=$?
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
[ "$run_status" -eq 0 ] && grep -q "Result: PASSED" sim.log || exit 1

/* sim/mp_endpoint_assert.sv */
// Concurrent checks on the endpoint ports
// Bound into mp_endpoint from the testbench
`timescale 1ns/1ps
`default_nettype none

module mp_endpoint_assert (
   input  logic clk,
   input  logic rst,
   input  logic bus_ack,
   input  logic bus_err,
   input  logic [31:0] noc_out_flit,
   input  logic noc_out_last,
   input  logic noc_out_valid,
   input  logic noc_out_ready,
   input  logic irq
);
   // Offered flit holds until taken
   property out_flit_holds;
      @(posedge clk) disable iff (rst)
         noc_out_valid && !noc_out_ready |=>
            noc_out_valid && $stable(noc_out_flit) && $stable(noc_out_last);
   endproperty

   out_stable: assert property (out_flit_holds)
      else $error("NoC output changed while stalled");

   // Bus answers with one or the other
   ack_err_excl: assert property (@(posedge clk) !(bus_ack && bus_err))
      else $error("bus_ack and bus_err high together");

   irq_after_rst: assert property (@(posedge clk) rst |=> !irq)
      else $error("irq high in the cycle after reset");

endmodule

`default_nettype wire

/* sim/mp_endpoint_tb.sv */
// Testbench for the message passing endpoint
// Applies a table of egress, ingress, control and bad address tests,
// with random stalls on the NoC output
`timescale 1ns/1ps
`default_nettype none

module mp_endpoint_tb;

   // Test kinds in the table
   localparam logic [1:0] kind_egress = 2'd0;
   localparam logic [1:0] kind_ingress = 2'd1;
   localparam logic [1:0] kind_ctrl = 2'd2;
   localparam logic [1:0] kind_bad = 2'd3;
   localparam int num_tests = 8;
   localparam int wait_limit = 300;
   // Byte addresses of word indices 0, 1 and 2
   localparam logic [31:0] data_addr = 32'h0;
   localparam logic [31:0] ctrl_addr = 32'h4;
   localparam logic [31:0] bad_addr = 32'h8;

   typedef struct packed {
      logic [1:0] kind;
      logic en_first;
      logic [4:0] size;
      logic [31:0] header;
      logic [31:0] reply;
   } test_t;

   logic clk;
   logic rst;
   logic [31:0] bus_addr;
   logic bus_we;
   logic bus_en;
   logic [31:0] bus_data_in;
   logic [31:0] bus_data_out;
   logic bus_ack;
   logic bus_err;
   logic [31:0] noc_in_flit;
   logic noc_in_last;
   logic noc_in_valid;
   logic noc_in_ready;
   logic [31:0] noc_out_flit;
   logic noc_out_last;
   logic noc_out_valid;
   logic noc_out_ready;
   logic irq;

   test_t tests [num_tests];
   // Flits taken from the NoC output with the last marker in bit 32
   logic [32:0] out_q [$];
   logic [31:0] lfsr;
   logic out_hold;
   logic ctrl_phase;
   logic irq_seen;
   logic exp_en;
   // Result of the latest bus access
   logic [31:0] rd_word;
   logic acc_ack;
   logic acc_err;
   int errors;
   int failed_tests;
   int err_before;
   int t;

   mp_endpoint dut (
      .clk           (clk),
      .rst           (rst),
      .bus_addr      (bus_addr),
      .bus_we        (bus_we),
      .bus_en        (bus_en),
      .bus_data_in   (bus_data_in),
      .bus_data_out  (bus_data_out),
      .bus_ack       (bus_ack),
      .bus_err       (bus_err),
      .noc_in_flit   (noc_in_flit),
      .noc_in_last   (noc_in_last),
      .noc_in_valid  (noc_in_valid),
      .noc_in_ready  (noc_in_ready),
      .noc_out_flit  (noc_out_flit),
      .noc_out_last  (noc_out_last),
      .noc_out_valid (noc_out_valid),
      .noc_out_ready (noc_out_ready),
      .irq           (irq)
   );

   bind mp_endpoint mp_endpoint_assert u_assert (
      .clk           (clk),
      .rst           (rst),
      .bus_ack       (bus_ack),
      .bus_err       (bus_err),
      .noc_out_flit  (noc_out_flit),
      .noc_out_last  (noc_out_last),
      .noc_out_valid (noc_out_valid),
      .noc_out_ready (noc_out_ready),
      .irq           (irq)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   // Packet words start with the header and go on with a pattern of header and index
   function automatic logic [31:0] pkt_flit(input logic [31:0] header, input int idx);
      if (idx == 0) begin
         return header;
      end
      return header ^ (32'h9e3779b9 * 32'(idx));
   endfunction

   function automatic string kind_name(input logic [1:0] kind);
      case (kind)
         kind_egress: return "egress";
         kind_ingress: return "ingress";
         kind_ctrl: return "control";
         default: return "bad address";
      endcase
   endfunction

   // NoC output model takes ready from one LFSR bit per cycle unless held
   always @(negedge clk) begin
      if (out_hold) begin
         noc_out_ready = 1'b0;
      end else begin
         noc_out_ready = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
      // Values here are what the next rising edge sees
      #2;
      if (noc_out_valid && noc_out_ready) begin
         out_q.push_back({noc_out_last, noc_out_flit});
      end
      if (ctrl_phase && irq) begin
         irq_seen = 1'b1;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      errors++;
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      $display("Result: FAILED");
      $finish;
   endtask

   // One bus access with the request held until ack or err
   task automatic bus_access(input logic [31:0] addr, input logic we, input logic [31:0] data);
      int cnt;
      @(negedge clk);
      bus_addr = addr;
      bus_we = we;
      bus_data_in = data;
      bus_en = 1'b1;
      cnt = 0;
      #1;
      while (!bus_ack && !bus_err && cnt < wait_limit) begin
         @(negedge clk);
         #1;
         cnt++;
      end
      if (!bus_ack && !bus_err) begin
         stop_on_timeout("a bus answer");
      end
      acc_ack = bus_ack;
      acc_err = bus_err;
      rd_word = bus_data_out;
      // Access completes on the rising edge in between
      @(negedge clk);
      bus_en = 1'b0;
      bus_we = 1'b0;
   endtask

   // Injects one packet on the NoC input
   task automatic noc_send(input logic [31:0] header, input int size);
      int cnt;
      int i;
      for (i = 0; i < size; i++) begin
         @(negedge clk);
         noc_in_flit = pkt_flit(header, i);
         noc_in_last = (i == size - 1);
         noc_in_valid = 1'b1;
         cnt = 0;
         #1;
         while (!noc_in_ready && cnt < wait_limit) begin
            @(negedge clk);
            #1;
            cnt++;
         end
         if (!noc_in_ready) begin
            stop_on_timeout("noc_in_ready");
         end
      end
      @(negedge clk);
      noc_in_valid = 1'b0;
      noc_in_last = 1'b0;
   endtask

   task automatic wait_out_flits(input int n);
      int cnt;
      cnt = 0;
      while (out_q.size() < n && cnt < wait_limit) begin
         @(negedge clk);
         #3;
         cnt++;
      end
      if (out_q.size() < n) begin
         stop_on_timeout("flits on the NoC output");
      end
   endtask

   task automatic wait_irq();
      int cnt;
      cnt = 0;
      while (!irq && cnt < wait_limit) begin
         @(negedge clk);
         cnt++;
      end
      if (!irq) begin
         stop_on_timeout("irq");
      end
   endtask

   // Size then flits from the bus are checked on the NoC output
   task automatic run_egress(input test_t tc);
      int i;
      out_q.delete();
      @(posedge clk);
      out_hold = 1'b1;
      bus_access(data_addr, 1'b1, 32'(tc.size));
      for (i = 0; i < int'(tc.size); i++) begin
         bus_access(data_addr, 1'b1, pkt_flit(tc.header, i));
      end
      // Output held, so the packet still waits
      bus_access(ctrl_addr, 1'b0, 32'h0);
      if (rd_word !== {29'b0, exp_en, 1'b1, 1'b0}) report_mismatch("status", rd_word,
                                                                  {29'b0, exp_en, 2'b10});
      @(posedge clk);
      out_hold = 1'b0;
      wait_out_flits(int'(tc.size));
      for (i = 0; i < int'(tc.size); i++) begin
         if (out_q[i][31:0] !== pkt_flit(tc.header, i)) report_mismatch("noc_out_flit",
                                                                       out_q[i][31:0],
                                                                       pkt_flit(tc.header, i));
         if (out_q[i][32] !== (i == int'(tc.size) - 1)) report_mismatch("noc_out_last",
                                                                      32'(out_q[i][32]),
                                                                      32'(i == tc.size - 1));
      end
      // Final flit is taken on this edge and nothing may follow it
      @(posedge clk);
      #1;
      if (noc_out_valid !== 1'b0) report_mismatch("noc_out_valid", 32'(noc_out_valid), 32'h0);
   endtask

   // Packet from the NoC is read back over the bus
   task automatic run_ingress(input test_t tc);
      int i;
      noc_send(tc.header, int'(tc.size));
      wait_irq();
      bus_access(data_addr, 1'b0, 32'h0);
      if (rd_word !== 32'(tc.size)) report_mismatch("size word", rd_word, 32'(tc.size));
      for (i = 0; i < int'(tc.size); i++) begin
         bus_access(data_addr, 1'b0, 32'h0);
         if (rd_word !== pkt_flit(tc.header, i)) report_mismatch("bus_data_out", rd_word,
                                                                pkt_flit(tc.header, i));
      end
      if (irq !== 1'b0) report_mismatch("irq", 32'(irq), 32'h0);
      // Nothing left to read
      bus_access(data_addr, 1'b0, 32'h0);
      if (rd_word !== 32'h0) report_mismatch("empty read", rd_word, 32'h0);
   endtask

   // Control request is answered on the NoC output and never seen by software
   task automatic run_ctrl(input test_t tc);
      out_q.delete();
      @(posedge clk);
      irq_seen = 1'b0;
      ctrl_phase = 1'b1;
      noc_send(tc.header, 1);
      wait_out_flits(1);
      if (out_q[0][31:0] !== tc.reply) report_mismatch("reply flit", out_q[0][31:0], tc.reply);
      if (out_q[0][32] !== 1'b1) report_mismatch("reply last", 32'(out_q[0][32]), 32'h1);
      if (irq_seen !== 1'b0) report_mismatch("irq", 32'(irq_seen), 32'h0);
      @(posedge clk);
      ctrl_phase = 1'b0;
   endtask

   // Unmapped word index 2 is tried with a read and then a write
   task automatic run_bad();
      int i;
      for (i = 0; i < 2; i++) begin
         bus_access(bad_addr, i[0], 32'h5a5a5a5a);
         if (acc_err !== 1'b1) report_mismatch("bus_err", 32'(acc_err), 32'h1);
         if (acc_ack !== 1'b0) report_mismatch("bus_ack", 32'(acc_ack), 32'h0);
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      bus_addr = '0;
      bus_we = 1'b0;
      bus_en = 1'b0;
      bus_data_in = '0;
      noc_in_flit = '0;
      noc_in_last = 1'b0;
      noc_in_valid = 1'b0;
      noc_out_ready = 1'b0;
      lfsr = 32'hc54d1f77;
      out_hold = 1'b0;
      ctrl_phase = 1'b0;
      irq_seen = 1'b0;
      exp_en = 1'b0;
      errors = 0;
      failed_tests = 0;

      // Kind, enable first, size, header, expected reply
      // Header is dest 31:27, class 26:24, src 23:19
      tests[0] = '{kind_egress, 1'b0, 5'd5, 32'h21100000, 32'h0};
      tests[1] = '{kind_ingress, 1'b0, 5'd4, 32'h12300000, 32'h0};
      tests[2] = '{kind_ctrl, 1'b0, 5'd1, 32'h1f4800a0, 32'h4f1800a1};
      tests[3] = '{kind_ctrl, 1'b1, 5'd1, 32'ha7281230, 32'h2fa01233};
      tests[4] = '{kind_egress, 1'b0, 5'd8, 32'h39280000, 32'h0};
      tests[5] = '{kind_ingress, 1'b0, 5'd3, 32'h13380004, 32'h0};
      tests[6] = '{kind_ctrl, 1'b0, 5'd1, 32'h1f4800a0, 32'h4f1800a3};
      tests[7] = '{kind_bad, 1'b0, 5'd0, 32'h0, 32'h0};

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Idle state straight after reset
      if (irq !== 1'b0) report_mismatch("irq", 32'(irq), 32'h0);
      if (noc_out_valid !== 1'b0) report_mismatch("noc_out_valid", 32'(noc_out_valid), 32'h0);
      bus_access(ctrl_addr, 1'b0, 32'h0);
      if (rd_word !== 32'h0) report_mismatch("status", rd_word, 32'h0);
      if (errors != 0) begin
         failed_tests++;
      end
      $display("Test reset: %s", (errors == 0) ? "pass" : "fail");

      for (t = 0; t < num_tests; t++) begin
         err_before = errors;
         if (tests[t].en_first) begin
            bus_access(ctrl_addr, 1'b1, 32'h1);
            exp_en = 1'b1;
         end
         case (tests[t].kind)
            kind_egress: run_egress(tests[t]);
            kind_ingress: run_ingress(tests[t]);
            kind_ctrl: run_ctrl(tests[t]);
            default: run_bad();
         endcase
         if (errors != err_before) begin
            failed_tests++;
         end
         $display("Test %0d %s: %s", t, kind_name(tests[t].kind),
                  (errors == err_before) ? "pass" : "fail");
      end

      $display("Tests run: %0d, failed: %0d, mismatches: %0d", num_tests + 1, failed_tests,
               errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
